// File: drum_trigger_top.f
src/drum_pkg.sv
src/drum_if.sv
src/board_timer.sv
src/button_debouncer.sv
src/sensor_spi_master.sv
src/imu_reader.sv
src/drum_trigger_processor.sv
src/drum_spi_slave.sv
src/drum_trigger_top.sv
bench/drum_trigger_checker.sv
bench/drum_trigger_tb.sv

// File: bench/drum_trigger_tb.sv
// Drum trigger testbench
// Two sensor models on the shared bus, buttons and an MCU reader drive the DUT,
// byte checks plus the bound checker decide the result
module drum_trigger_tb;

    localparam int TIMEOUT_CYCLES = 4000;   // About 12 frames, 6 MCU reads and reset, with margin

    logic clk, fpga_rst_n;
    logic mcu_sck, mcu_sdi, mcu_load, mcu_sdo, mcu_done;
    logic sclk, mosi, cs_n1, cs_n2, bno085_rst_n;
    logic miso1, int1, miso2, int2;
    logic calibrate_btn_n, kick_btn_n;
    logic led_initialized, led_error, led_heartbeat;

    logic [39:0] frame_r, frame_l;          // Echo byte, yaw, pitch rate
    logic [39:0] shift_r, shift_l;
    logic [39:0] mosi_seen;                 // Bytes the master sent in the current frame
    int          mosi_bits;
    logic        in_frame;
    int          errors;
    int          mark;                      // Error total at test start
    int          tests_run, tests_bad;
    int          cycles;

    drum_trigger_top DUT (.*);

    bind drum_trigger_top drum_trigger_checker u_checker (
        .clk, .fpga_rst_n, .cs_n1, .cs_n2, .sclk, .mcu_done, .mcu_load, .bno085_rst_n,
        .led_initialized, .led_error, .led_heartbeat);

    always #2 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ==============================
    // Sensor models
    // ==============================
    always @(negedge cs_n1) begin
        #1;
        int1    = 1'b1;                     // Interrupt served
        shift_r = frame_r;
        miso1   = shift_r[39];
    end

    always @(negedge cs_n2) begin
        #1;
        int2    = 1'b1;
        shift_l = frame_l;
        miso2   = shift_l[39];
    end

    // Mode 0, next bit after each falling sclk
    always @(negedge sclk) begin
        #1;
        if (!cs_n1) begin
            shift_r = shift_r << 1;
            miso1   = shift_r[39];
        end
        if (!cs_n2) begin
            shift_l = shift_l << 1;
            miso2   = shift_l[39];
        end
    end

    // Command side of a frame, one READ_CMD then four zero bytes
    always @(negedge cs_n1 or negedge cs_n2) begin
        mosi_seen = '0;
        mosi_bits = 0;
        in_frame  = 1'b1;
    end

    always @(posedge sclk) begin
        if (!cs_n1 || !cs_n2) begin
            mosi_seen = {mosi_seen[38:0], mosi};
            mosi_bits++;
        end
    end

    always @(posedge cs_n1 or posedge cs_n2) begin
        if (in_frame) begin
            in_frame = 1'b0;
            assert (mosi_bits == 40 && mosi_seen == {drum_pkg::READ_CMD, 32'h0})
            else begin
                $display("[ERROR] %0t: frame sent %0d bits 0x%010h on mosi",
                         $time, mosi_bits, mosi_seen);
                errors++;
            end
        end
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic tick();
        @(posedge clk);
        #1;                                 // Drive and sample away from the edge
    endtask

    function automatic int total_errors();
        return errors + DUT.u_checker.err_cnt;
    endfunction

    function automatic logic [7:0] event_byte(input logic left, input logic [3:0] code);
        return {1'b1, left, 2'b00, code};
    endfunction

    // Zone 0 low side, 1 centre, 2 high side
    function automatic logic [3:0] zone_drum(input logic left, input int zone);
        case (zone)
            0:       return left ? drum_pkg::CRASH : drum_pkg::HIHAT;
            1:       return left ? drum_pkg::TOM_HIGH : drum_pkg::SNARE;
            default: return left ? drum_pkg::TOM_LOW : drum_pkg::RIDE;
        endcase
    endfunction

    function automatic logic signed [15:0] pick_yaw(input int zone,
                                                    input logic signed [15:0] zero);
        int off;
        case (zone)
            0:       off = -int'(drum_pkg::ZONE_EDGE) - 1 - int'($urandom % 15000);
            1:       off = int'($urandom % 6001) - 3000;
            default: off = int'(drum_pkg::ZONE_EDGE) + 1 + int'($urandom % 15000);
        endcase
        return 16'(int'(zero) + off);
    endfunction

    function automatic logic signed [15:0] strike_rate();
        return 16'(int'(drum_pkg::STRIKE_THRESH) - int'($urandom % 3000));
    endfunction

    task automatic wait_frame(input logic left);
        do tick(); while ((left ? cs_n2 : cs_n1) == 1'b1);
        do tick(); while ((left ? cs_n2 : cs_n1) == 1'b0);
    endtask

    task automatic send_frame(input logic left, input logic signed [15:0] yaw,
                              input logic signed [15:0] rate);
        if (left) begin
            frame_l = {8'h00, yaw, rate};
            int2    = 1'b0;
        end else begin
            frame_r = {8'h00, yaw, rate};
            int1    = 1'b0;
        end
        wait_frame(left);
    endtask

    // Load high, 8 sck periods of 4 clk, load low
    task automatic mcu_read(output logic [7:0] data);
        int n;
        mcu_load = 1'b1;
        repeat (3) tick();                  // Let the slave see load first
        for (int i = 7; i >= 0; i--) begin
            mcu_sck = 1'b0;
            repeat (2) tick();
            data[i] = mcu_sdo;
            mcu_sck = 1'b1;
            repeat (2) tick();
        end
        mcu_sck = 1'b0;
        repeat (2) tick();
        mcu_load = 1'b0;
        n = 0;
        while (mcu_done && n < 3) begin
            tick();
            n++;
        end
        assert (!mcu_done)
        else begin
            $display("mcu_done stayed high after the MCU dropped load");
            errors++;
        end
    endtask

    task automatic expect_event(input logic [7:0] exp, input string what);
        logic [7:0] got;
        int         n;
        n = 0;
        while (!mcu_done && n < 30) begin
            tick();
            n++;
        end
        if (!mcu_done) begin
            $display("No event reached the MCU port for %s", what);
            errors++;
        end else begin
            mcu_read(got);
            assert (got == exp)
            else begin
                $display("[ERROR] %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
                errors++;
            end
        end
    endtask

    task automatic expect_no_event(input string what);
        repeat (12) tick();
        assert (!mcu_done)
        else begin
            $display("An event showed up at the MCU port after %s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, total_errors() - mark);
            tests_bad++;
        end
        mark = total_errors();
    endtask

    // ==============================
    // Tests
    // ==============================
    initial begin
        int                 n;
        int unsigned        seed_val;
        logic               hb0;
        logic signed [15:0] yaw, zero_r, y_cal;
        clk             = 1'b0;
        fpga_rst_n      = 1'b0;
        mcu_sck         = 1'b0;
        mcu_sdi         = 1'b0;
        mcu_load        = 1'b0;
        miso1           = 1'b0;
        miso2           = 1'b0;
        int1            = 1'b1;
        int2            = 1'b1;
        calibrate_btn_n = 1'b1;
        kick_btn_n      = 1'b1;
        frame_r         = '0;
        frame_l         = '0;
        shift_r         = '0;
        shift_l         = '0;
        mosi_seen       = '0;
        mosi_bits       = 0;
        in_frame        = 1'b0;
        errors          = 0;
        mark            = 0;
        tests_run       = 0;
        tests_bad       = 0;
        cycles          = 0;
        seed_val        = $urandom(50122);  // One seed for the whole run

        repeat (4) tick();
        fpga_rst_n = 1'b1;

        // Reset sequencing
        n = 0;
        while (!bno085_rst_n) begin
            tick();
            n++;
        end
        assert (n == drum_pkg::SENSOR_RST_CYCLES)
        else begin
            $display("[ERROR] %0t: sensor reset released after %0d cycles", $time, n);
            errors++;
        end
        while (!led_initialized) tick();
        hb0 = led_heartbeat;
        n   = 0;
        while (led_heartbeat == hb0 && n < drum_pkg::HEARTBEAT_DIV + 4) begin
            tick();
            n++;
        end
        assert (led_heartbeat != hb0)
        else begin
            $display("Heartbeat did not toggle after the controller release");
            errors++;
        end
        end_test("reset sequencing");

        // Right hand, one strike per zone, rearm in between
        for (int z = 0; z < 3; z++) begin
            yaw = pick_yaw(z, 16'sd0);
            send_frame(1'b0, yaw, strike_rate());
            expect_event(event_byte(1'b0, zone_drum(1'b0, z)), "right strike");
            send_frame(1'b0, yaw, 16'sd0);
        end
        zero_r = yaw;                       // Right heading at calibration
        end_test("right zones");

        // Y kept low enough that uncalibrated zoning says TOM_HIGH
        y_cal = 16'(-200 - int'($urandom % 7800));
        send_frame(1'b1, y_cal, 16'sd0);
        calibrate_btn_n = 1'b0;
        repeat (drum_pkg::DEBOUNCE_CYCLES + 4) tick();
        calibrate_btn_n = 1'b1;
        repeat (drum_pkg::DEBOUNCE_CYCLES + 4) tick();
        yaw = y_cal + drum_pkg::ZONE_EDGE + 16'sd100;
        send_frame(1'b1, yaw, strike_rate());
        expect_event(event_byte(1'b1, drum_pkg::TOM_LOW), "calibrated left strike");
        send_frame(1'b1, yaw, 16'sd0);
        end_test("calibration");

        // Both interrupts together, right wins the bus and the event slot
        frame_r = {8'h00, pick_yaw(1, zero_r), strike_rate()};
        frame_l = {8'h00, pick_yaw(1, y_cal), strike_rate()};
        int1    = 1'b0;
        int2    = 1'b0;
        wait_frame(1'b0);
        wait_frame(1'b1);
        expect_event(event_byte(1'b0, drum_pkg::SNARE), "contended right strike");
        expect_no_event("the dropped left strike");
        end_test("contention");

        // Right hand still disarmed, then the kick
        send_frame(1'b0, zero_r, strike_rate());
        expect_no_event("a strike without rearm");
        kick_btn_n = 1'b0;
        expect_event(event_byte(1'b0, drum_pkg::KICK), "kick");
        kick_btn_n = 1'b1;
        repeat (drum_pkg::DEBOUNCE_CYCLES + 4) tick();
        end_test("rearm and kick");

        $display("tests run %0d, tests with errors %0d, bench errors %0d, assertion errors %0d",
                 tests_run, tests_bad, errors, DUT.u_checker.err_cnt);
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: bench/drum_trigger_checker.sv
// Drum trigger protocol checker
// Bound into the top level, watches the sensor bus, reset release and MCU port
module drum_trigger_checker (
    input logic clk,
    input logic fpga_rst_n,
    input logic cs_n1,
    input logic cs_n2,
    input logic sclk,
    input logic mcu_done,
    input logic mcu_load,
    input logic bno085_rst_n,
    input logic led_initialized,    // Follows the controller reset release
    input logic led_error,
    input logic led_heartbeat
);

    int err_cnt = 0;                // Read by the testbench summary

    // ==============================
    // Sensor bus
    // ==============================
    cs_exclusive: assert property (@(posedge clk) disable iff (!fpga_rst_n)
        cs_n1 || cs_n2)
        else begin
            $error("both sensor chip selects low together");
            err_cnt++;
        end

    // Everything quiet until the controllers are released
    idle_before_release: assert property (@(posedge clk) disable iff (!fpga_rst_n)
        !led_initialized |-> cs_n1 && cs_n2 && !sclk && !mcu_done &&
                             !led_error && !led_heartbeat)
        else begin
            $error("outputs active before controller release");
            err_cnt++;
        end

    sensor_rst_release: assert property (@(posedge clk)
        $rose(fpga_rst_n) |-> !bno085_rst_n [*drum_pkg::SENSOR_RST_CYCLES] ##1 bno085_rst_n)
        else begin
            $error("sensor reset not released at its fixed count");
            err_cnt++;
        end

    // ==============================
    // MCU port
    // ==============================
    // Done only drops within 3 cycles after load fell
    done_held: assert property (@(posedge clk) disable iff (!fpga_rst_n)
        $fell(mcu_done) |-> !mcu_load &&
                            ($past(mcu_load, 2) || $past(mcu_load, 3) || $past(mcu_load, 4)))
        else begin
            $error("mcu_done dropped without a falling mcu_load");
            err_cnt++;
        end

endmodule

// File: src/drum_trigger_top.sv
// Drum trigger subsystem top level
// Two inertial sensors on one SPI bus, strike to drum code conversion,
// buttons, board reset sequencing and the MCU event port
module drum_trigger_top (
    input  logic clk,
    input  logic fpga_rst_n,
    // MCU port
    input  logic mcu_sck,
    input  logic mcu_sdi,           // No commands from the MCU yet
    input  logic mcu_load,
    output logic mcu_sdo,
    output logic mcu_done,
    // Sensor bus, shared sclk/mosi/reset
    output logic sclk,
    output logic mosi,
    output logic cs_n1,
    output logic cs_n2,
    output logic bno085_rst_n,
    input  logic miso1,
    input  logic int1,
    input  logic miso2,
    input  logic int2,
    // Buttons, active low
    input  logic calibrate_btn_n,
    input  logic kick_btn_n,
    // Status
    output logic led_initialized,
    output logic led_error,
    output logic led_heartbeat
);

    logic                 ctrl_rst_n;               // Reset for everything but the timer
    logic                 calibrate_p, kick_p;      // Debounced press pulses
    logic                 event_valid;
    drum_pkg::drum_code_e event_code;
    drum_pkg::hand_e      event_hand;

    spi_byte_if   spi_r ();
    spi_byte_if   spi_l ();
    imu_sample_if smp_r ();
    imu_sample_if smp_l ();

    board_timer u_timer (.clk, .fpga_rst_n, .bno085_rst_n, .ctrl_rst_n, .led_heartbeat);

    button_debouncer u_cal_db  (.clk, .rst_n(ctrl_rst_n), .btn_n(calibrate_btn_n),
                                .pressed(calibrate_p));
    button_debouncer u_kick_db (.clk, .rst_n(ctrl_rst_n), .btn_n(kick_btn_n), .pressed(kick_p));

    // ==============================
    // Sensor side
    // ==============================
    sensor_spi_master u_spi (.clk, .rst_n(ctrl_rst_n), .cli1(spi_r.master), .cli2(spi_l.master),
                             .miso1, .miso2, .sclk, .mosi);

    imu_reader #(.HAND(drum_pkg::RIGHT)) u_rd_r (.clk, .rst_n(ctrl_rst_n), .int_n(int1),
                                                 .cs_n(cs_n1), .spi(spi_r.client),
                                                 .smp(smp_r.source));
    imu_reader #(.HAND(drum_pkg::LEFT))  u_rd_l (.clk, .rst_n(ctrl_rst_n), .int_n(int2),
                                                 .cs_n(cs_n2), .spi(spi_l.client),
                                                 .smp(smp_l.source));

    // ==============================
    // Events to the MCU
    // ==============================
    drum_trigger_processor u_proc (.clk, .rst_n(ctrl_rst_n), .right(smp_r.sink),
                                   .left(smp_l.sink), .calibrate(calibrate_p), .kick(kick_p),
                                   .event_valid, .event_code, .event_hand);

    drum_spi_slave u_mcu (.clk, .rst_n(ctrl_rst_n), .sck(mcu_sck), .load(mcu_load),
                          .sdo(mcu_sdo), .done(mcu_done), .event_valid, .event_code,
                          .event_hand);

    assign led_initialized = ctrl_rst_n;    // Up once the controllers run
    assign led_error       = 1'b0;          // Reduced frame has no error report

endmodule

// File: src/drum_spi_slave.sv
// MCU event port
// Holds one event byte, raises done, and shifts the byte out on the MCU's sck
module drum_spi_slave (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sck,
    input  logic                 load,
    output logic                 sdo,
    output logic                 done,
    input  logic                 event_valid,
    input  drum_pkg::drum_code_e event_code,
    input  drum_pkg::hand_e      event_hand
);

    logic [2:0]           sck_q, load_q;    // Two sync flops plus edge history
    logic                 sck_rise, load_fall, load_s;
    logic                 ev_vld_q;
    drum_pkg::drum_code_e ev_code_q;
    drum_pkg::hand_e      ev_hand_q;
    logic [7:0]           shreg;

    assign load_s    = load_q[1];
    assign sck_rise  = sck_q[1] & ~sck_q[2];
    assign load_fall = ~load_q[1] & load_q[2];
    assign sdo       = shreg[7];            // Bit 7 waits here before the first rise

    always_ff @(posedge clk) begin
        ev_code_q <= event_code;
        ev_hand_q <= event_hand;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_q    <= '0;
            load_q   <= '0;
            ev_vld_q <= 1'b0;
            done     <= 1'b0;
            shreg    <= '0;
        end else begin
            sck_q    <= {sck_q[1:0], sck};
            load_q   <= {load_q[1:0], load};
            ev_vld_q <= event_valid;
            if (load_fall) begin
                done <= 1'b0;                   // MCU has its byte
            end else if (ev_vld_q && !done && !load_s) begin
                done  <= 1'b1;                  // Events while done is high are lost
                shreg <= {1'b1, ev_hand_q, 2'b00, ev_code_q};
            end else if (load_s && sck_rise) begin
                // Next bit settles while sck is low, ahead of the next rise
                shreg <= {shreg[6:0], 1'b0};
            end
        end
    end

endmodule

// File: src/drum_trigger_processor.sv
// Trigger processor
// Turns strikes of either hand into zoned drum codes, handles calibration
// and the kick, and emits at most one event per cycle
module drum_trigger_processor (
    input  logic                  clk,
    input  logic                  rst_n,
    imu_sample_if.sink            right,
    imu_sample_if.sink            left,
    input  logic                  calibrate,
    input  logic                  kick,
    output logic                  event_valid,
    output drum_pkg::drum_code_e  event_code,
    output drum_pkg::hand_e       event_hand
);

    // Index 0 right hand, 1 left hand
    logic                 smp_vld   [2];
    logic signed [15:0]   smp_yaw   [2];
    logic signed [15:0]   smp_rate  [2];
    logic                 armed     [2];
    logic signed [15:0]   offset    [2];    // Calibrated zero
    logic signed [15:0]   last_yaw  [2];
    logic                 pend      [2];    // One-deep per source
    drum_pkg::drum_code_e pend_code [2];
    logic                 pend_kick;
    logic [2:0]           serve;            // Right, left, kick

    assign smp_vld[0]  = right.valid;
    assign smp_vld[1]  = left.valid;
    assign smp_yaw[0]  = right.yaw;
    assign smp_yaw[1]  = left.yaw;
    assign smp_rate[0] = right.pitch_rate;
    assign smp_rate[1] = left.pitch_rate;

    // Low side, centre, high side of the calibrated yaw
    function automatic drum_pkg::drum_code_e zone_code(input logic is_left,
                                                       input logic signed [15:0] yaw,
                                                       input logic signed [15:0] zero);
        logic signed [15:0] rel;
        rel = yaw - zero;
        if (rel < -drum_pkg::ZONE_EDGE)
            return is_left ? drum_pkg::CRASH : drum_pkg::HIHAT;
        else if (rel > drum_pkg::ZONE_EDGE)
            return is_left ? drum_pkg::TOM_LOW : drum_pkg::RIDE;
        return is_left ? drum_pkg::TOM_HIGH : drum_pkg::SNARE;
    endfunction

    // Fixed order right, left, kick
    always_comb begin
        serve      = 3'b000;
        event_code = drum_pkg::NONE;
        event_hand = drum_pkg::RIGHT;
        if (pend[0]) begin
            serve[0]   = 1'b1;
            event_code = pend_code[0];
        end else if (pend[1]) begin
            serve[1]   = 1'b1;
            event_code = pend_code[1];
            event_hand = drum_pkg::LEFT;
        end else if (pend_kick) begin
            serve[2]   = 1'b1;
            event_code = drum_pkg::KICK;
        end
    end

    assign event_valid = |serve;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int h = 0; h < 2; h++) begin
                armed[h]     <= 1'b1;
                offset[h]    <= '0;
                last_yaw[h]  <= '0;
                pend[h]      <= 1'b0;
                pend_code[h] <= drum_pkg::NONE;
            end
            pend_kick <= 1'b0;
        end else begin
            for (int h = 0; h < 2; h++) begin
                if (serve[h])
                    pend[h] <= 1'b0;
                if (smp_vld[h]) begin
                    last_yaw[h] <= smp_yaw[h];
                    if (armed[h] && smp_rate[h] <= drum_pkg::STRIKE_THRESH) begin
                        armed[h]     <= 1'b0;       // One hit per swing
                        pend[h]      <= 1'b1;
                        pend_code[h] <= zone_code(h == 1, smp_yaw[h], offset[h]);
                    end else if (smp_rate[h] >= drum_pkg::REARM_THRESH) begin
                        armed[h] <= 1'b1;
                    end
                end
                if (calibrate)
                    offset[h] <= last_yaw[h];       // Current heading becomes centre
            end
            if (serve[2])
                pend_kick <= 1'b0;
            if (kick)
                pend_kick <= 1'b1;
        end
    end

endmodule

// File: src/imu_reader.sv
// Sensor frame reader
// On interrupt, wins the shared bus, reads command plus four bytes
// and hands yaw and pitch rate to the processor
module imu_reader #(
    parameter drum_pkg::hand_e HAND = drum_pkg::RIGHT
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         int_n,
    output logic         cs_n,
    spi_byte_if.client   spi,
    imu_sample_if.source smp
);

    typedef enum logic [1:0] {IDLE, REQ, XFER, DONE} state_e;

    state_e      state;
    logic [7:0]  rcvd;          // Bytes finished in this frame
    logic        inflight;      // Start sent, rx_valid not yet back
    logic [31:0] frame;         // Last four bytes, big-endian

    assign spi.tx_data    = (rcvd == 8'd0) ? drum_pkg::READ_CMD : 8'h00;
    assign smp.hand       = HAND;
    assign smp.yaw        = frame[31:16];
    assign smp.pitch_rate = frame[15:0];

    always_ff @(posedge clk) begin
        if (spi.rx_valid)
            frame <= {frame[23:0], spi.rx_data};   // Command echo falls off the top
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            cs_n      <= 1'b1;
            spi.req   <= 1'b0;
            spi.start <= 1'b0;
            smp.valid <= 1'b0;
            inflight  <= 1'b0;
            rcvd      <= '0;
        end else begin
            spi.start <= 1'b0;
            smp.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (!int_n) begin
                        spi.req <= 1'b1;
                        state   <= REQ;
                    end
                end
                REQ: begin                          // Wait for the other hand to finish
                    if (spi.grant) begin
                        cs_n  <= 1'b0;
                        rcvd  <= '0;
                        state <= XFER;
                    end
                end
                XFER: begin
                    if (spi.rx_valid) begin
                        inflight <= 1'b0;
                        rcvd     <= rcvd + 8'd1;
                        if (rcvd == drum_pkg::FRAME_BYTES - 8'd1)
                            state <= DONE;
                    end else if (!inflight && !spi.busy) begin
                        spi.start <= 1'b1;
                        inflight  <= 1'b1;
                    end
                end
                DONE: begin
                    cs_n      <= 1'b1;
                    spi.req   <= 1'b0;              // Frees the bus
                    smp.valid <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: src/sensor_spi_master.sv
// Shared sensor SPI master
// Grants the bus to one frame reader at a time and moves mode-0 bytes MSB first
module sensor_spi_master (
    input  logic       clk,
    input  logic       rst_n,
    spi_byte_if.master cli1,
    spi_byte_if.master cli2,
    input  logic       miso1,
    input  logic       miso2,
    output logic       sclk,
    output logic       mosi
);

    logic       g1, g2;             // Exclusive grants
    logic       busy, rx_vld;
    logic       start_ok, miso_sel;
    logic [7:0] div;                // clk count inside a half period
    logic [3:0] half;               // Even halves sclk low, odd halves high
    logic [7:0] tx_sh, rx_sh;

    assign start_ok = !busy && ((g1 && cli1.start) || (g2 && cli2.start));
    assign miso_sel = g2 ? miso2 : miso1;
    assign mosi     = tx_sh[7];

    assign cli1.grant    = g1;
    assign cli2.grant    = g2;
    assign cli1.busy     = busy;
    assign cli2.busy     = busy;
    assign cli1.rx_data  = rx_sh;
    assign cli2.rx_data  = rx_sh;
    assign cli1.rx_valid = rx_vld && g1;
    assign cli2.rx_valid = rx_vld && g2;

    // Owner keeps the bus until its req drops, ties go to client 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            g1 <= 1'b0;
            g2 <= 1'b0;
        end else if (g1) begin
            g1 <= cli1.req;
        end else if (g2) begin
            g2 <= cli2.req;
        end else begin
            g1 <= cli1.req;
            g2 <= !cli1.req && cli2.req;
        end
    end

    // ==============================
    // Byte engine
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rx_vld <= 1'b0;
            sclk   <= 1'b0;
            div    <= '0;
            half   <= '0;
            tx_sh  <= '0;
            rx_sh  <= '0;
        end else begin
            rx_vld <= 1'b0;
            if (start_ok) begin
                busy  <= 1'b1;
                div   <= '0;
                half  <= '0;
                tx_sh <= g1 ? cli1.tx_data : cli2.tx_data;  // MSB on mosi before first rise
            end else if (busy) begin
                if (div == drum_pkg::SCLK_HALF - 8'd1) begin
                    div  <= '0;
                    sclk <= ~sclk;
                    half <= half + 4'd1;
                    if (!half[0])
                        rx_sh <= {rx_sh[6:0], miso_sel};    // Rising edge samples
                    else
                        tx_sh <= {tx_sh[6:0], 1'b0};        // Falling edge shifts
                    if (half == 4'd15) begin
                        busy   <= 1'b0;                     // sclk back low here
                        rx_vld <= 1'b1;
                    end
                end else begin
                    div <= div + 8'd1;
                end
            end
        end
    end

endmodule

// File: src/button_debouncer.sv
// Button debouncer
// Synchronizes an active-low button and gives one pulse per accepted press
module button_debouncer (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_n,
    output logic pressed
);

    logic [1:0] sync;       // sync[1] is the clean level
    logic       level;      // Accepted button level, 1 = released
    logic [7:0] stable_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync       <= 2'b11;    // Idle high
            level      <= 1'b1;
            stable_cnt <= '0;
            pressed    <= 1'b0;
        end else begin
            sync    <= {sync[0], btn_n};
            pressed <= 1'b0;
            if (sync[1] == level) begin
                stable_cnt <= '0;                   // Bounce restarts the wait
            end else if (stable_cnt == drum_pkg::DEBOUNCE_CYCLES - 8'd1) begin
                stable_cnt <= '0;
                level      <= sync[1];
                pressed    <= ~sync[1];             // Only the falling level counts
            end else begin
                stable_cnt <= stable_cnt + 8'd1;
            end
        end
    end

endmodule

// File: src/board_timer.sv
// Board timer
// Releases the sensor reset, then the controller reset, and blinks the heartbeat
module board_timer (
    input  logic clk,
    input  logic fpga_rst_n,
    output logic bno085_rst_n,
    output logic ctrl_rst_n,
    output logic led_heartbeat
);

    logic [7:0] rst_cnt;    // Saturates at the controller release
    logic [7:0] hb_cnt;

    always_ff @(posedge clk or negedge fpga_rst_n) begin
        if (!fpga_rst_n) begin
            rst_cnt      <= '0;
            bno085_rst_n <= 1'b0;
            ctrl_rst_n   <= 1'b0;
        end else begin
            if (rst_cnt != drum_pkg::CTRL_RST_CYCLES)
                rst_cnt <= rst_cnt + 8'd1;
            // Registered compare lands the release exactly on the count
            bno085_rst_n <= (rst_cnt >= drum_pkg::SENSOR_RST_CYCLES - 8'd1);
            ctrl_rst_n   <= (rst_cnt >= drum_pkg::CTRL_RST_CYCLES - 8'd1);
        end
    end

    // Heartbeat runs only with the controllers out of reset
    always_ff @(posedge clk or negedge fpga_rst_n) begin
        if (!fpga_rst_n) begin
            hb_cnt        <= '0;
            led_heartbeat <= 1'b0;
        end else if (!ctrl_rst_n) begin
            hb_cnt        <= '0;
            led_heartbeat <= 1'b0;
        end else if (hb_cnt == drum_pkg::HEARTBEAT_DIV - 8'd1) begin
            hb_cnt        <= '0;
            led_heartbeat <= ~led_heartbeat;
        end else begin
            hb_cnt <= hb_cnt + 8'd1;
        end
    end

endmodule

// File: src/drum_if.sv
// Internal bundles of the drum trigger
// spi_byte_if links a frame reader to the shared SPI master,
// imu_sample_if carries one decoded sample to the trigger processor

interface spi_byte_if;
    logic       req;        // Held for a whole frame
    logic       start;      // One byte, only while granted and idle
    logic [7:0] tx_data;
    logic       grant;      // Bus owned until req falls
    logic [7:0] rx_data;
    logic       rx_valid;   // Eighth bit sampled
    logic       busy;

    modport master (input req, start, tx_data, output grant, rx_data, rx_valid, busy);
    modport client (output req, start, tx_data, input grant, rx_data, rx_valid, busy);
endinterface

interface imu_sample_if;
    logic               valid;          // One pulse per frame, never stalled
    drum_pkg::hand_e    hand;
    logic signed [15:0] yaw;
    logic signed [15:0] pitch_rate;

    modport source (output valid, hand, yaw, pitch_rate);
    modport sink   (input valid, hand, yaw, pitch_rate);
endinterface

// File: src/drum_pkg.sv
// Drum trigger shared definitions
// Scaled timing constants, strike thresholds, frame layout and event codes
package drum_pkg;

    // ==============================
    // Timing, scaled for simulation
    // ==============================
    localparam logic [7:0] SENSOR_RST_CYCLES = 8'd8;    // fpga_rst_n high to sensor reset release
    localparam logic [7:0] CTRL_RST_CYCLES   = 8'd32;   // fpga_rst_n high to controller release
    localparam logic [7:0] HEARTBEAT_DIV     = 8'd16;   // Cycles between heartbeat toggles
    localparam logic [7:0] DEBOUNCE_CYCLES   = 8'd4;    // Stable cycles before a level is taken
    localparam logic [7:0] SCLK_HALF         = 8'd2;    // clk cycles per sclk half period

    // ==============================
    // Sensor frame
    // ==============================
    localparam logic [7:0] FRAME_BYTES = 8'd5;          // Command, yaw hi/lo, rate hi/lo
    localparam logic [7:0] READ_CMD    = 8'h80;         // First byte of every frame

    // Pitch rate levels, a strike is a fast downward swing
    localparam logic signed [15:0] STRIKE_THRESH = -16'sd2000;
    localparam logic signed [15:0] REARM_THRESH  = -16'sd500;
    localparam logic signed [15:0] ZONE_EDGE     = 16'sd4000;  // Side zones start here

    // Codes sent to the MCU in the low nibble
    typedef enum logic [3:0] {
        NONE     = 4'd0,
        SNARE    = 4'd1,
        HIHAT    = 4'd2,
        RIDE     = 4'd3,
        TOM_HIGH = 4'd4,
        TOM_LOW  = 4'd5,
        CRASH    = 4'd6,
        KICK     = 4'd7
    } drum_code_e;

    typedef enum logic {RIGHT = 1'b0, LEFT = 1'b1} hand_e;

endpackage
